//--- useq_defs.svh
`ifndef USEQ_DEFS_SVH
`define USEQ_DEFS_SVH

// cluster size
`define USEQ_NCORES     4      // number of microsequencer cores

// per-core sizes
`define USEQ_FIFO_DEPTH 8      // mailbox entries, fill level needs 4 bits
`define USEQ_ROM_AW     8      // pc and program rom address width

// interrupt entry point, shared by every core
`define USEQ_ISR_VECT   8'h40

// wishbone word address, [3:2] core, [1:0] register
`define USEQ_WB_AW      4

`endif

//--- useq_pkg.sv
package useq_pkg;

	// low byte of each 16-bit instruction word, immediate sits in the high byte
	typedef enum logic [7:0] {
		NOP  = 8'h00,  // no operation
		LDI  = 8'h01,  // a = imm
		ADDP = 8'h02,  // a = a + latched i_port
		POPF = 8'h03,  // a = mailbox head, waits while empty
		OUT  = 8'h04,  // o_port = a, toggle pulse
		JMP  = 8'h05,  // pc = imm
		SEI  = 8'h06,  // int mask = imm, enable interrupts
		RTI  = 8'h07   // restore pc and a, re-enable interrupts
	} opcode_t;

	// three cycles per instruction
	typedef enum logic [1:0] {
		FETCH   = 2'd0,  // rom address out, waits here while halted
		DECODE  = 2'd1,  // rom data valid, latch opcode and immediate
		EXECUTE = 2'd2   // perform the operation
	} core_state_t;

	// host-visible status register layout
	typedef struct packed {
		logic       run;    // core enabled
		logic       drop;   // sticky, a push hit a full mailbox
		logic       full;
		logic       empty;
		logic [3:0] count;  // mailbox fill level
	} mbox_status_t;

endpackage

//--- useq_mbox_if.sv
`timescale 1ns/1ps

// host block to core link, one per core
interface useq_mbox_if;
	logic       push;   // one-cycle strobe, only raised while full is low
	logic [7:0] wdata;  // byte written on push
	logic       run;    // core enable from the control register
	logic [3:0] count;  // mailbox fill level
	logic       full;   // count at fifo depth

	modport host (
		output push, wdata, run,
		input  count, full
	);

	modport core (
		input  push, wdata, run,
		output count, full
	);
endinterface

//--- useq_rom.sv
`timescale 1ns/1ps
`include "useq_defs.svh"

module useq_rom (
	input  logic                    clk,
	input  logic [`USEQ_ROM_AW-1:0] addr,
	output logic [15:0]             data
);
	localparam int WORDS = 2 ** `USEQ_ROM_AW;

	logic [15:0] mem [WORDS];  // {imm, opcode} per word

	// unused words decode as NOP
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = 16'h0000;
		end
		$readmemh("useq_prog.hex", mem);
	end

	// one cycle read latency, covered by the core's FETCH state
	always_ff @(posedge clk) begin
		data <= mem[addr];
	end

endmodule

//--- useq_core.sv
`timescale 1ns/1ps
`include "useq_defs.svh"

module useq_core (
	input  logic                    clk,
	input  logic                    rst_n,
	useq_mbox_if.core               mbox,
	output logic [`USEQ_ROM_AW-1:0] rom_addr,
	input  logic [15:0]             rom_data,
	input  logic [7:0]              i_port,
	output logic [7:0]              o_port,
	output logic                    o_port_pulse
);
	localparam int DEPTH = `USEQ_FIFO_DEPTH;
	localparam int PW    = $clog2(DEPTH);

	useq_pkg::core_state_t   state;
	useq_pkg::opcode_t       instr;     // current opcode
	logic [7:0]              imm;       // current immediate
	logic [`USEQ_ROM_AW-1:0] pc;        // points at the instruction in flight
	logic [`USEQ_ROM_AW-1:0] ilr;       // pc saved on interrupt
	logic [7:0]              a;         // accumulator
	logic [7:0]              ta;        // a saved on interrupt
	logic [7:0]              l_i_port;  // i_port from the previous cycle
	logic [7:0]              int_mask;  // set by SEI
	logic                    int_en;    // cleared on entry, set by SEI and RTI
	logic                    int_hit;

	// mailbox storage
	logic [7:0]    fifo_mem [DEPTH];
	logic [PW-1:0] wptr;
	logic [PW-1:0] rptr;
	logic [3:0]    fcount;
	logic          pop;

	assign rom_addr = pc;  // rom registers it, data ready in DECODE

	// rising edge on an unmasked bit, only taken while running
	assign int_hit = int_en && mbox.run && |((i_port & ~l_i_port) & int_mask);

	// POPF retires only with a byte available and no interrupt in the same cycle
	assign pop = (state == useq_pkg::EXECUTE) && (instr == useq_pkg::POPF) &&
		(fcount != 4'd0) && !int_hit;

	assign mbox.count = fcount;
	assign mbox.full  = (fcount == 4'(DEPTH));

	always_ff @(posedge clk) begin
		if (mbox.push) begin
			fifo_mem[wptr] <= mbox.wdata;  // host never pushes into a full mailbox
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr   <= '0;
			rptr   <= '0;
			fcount <= 4'd0;
		end else begin
			if (mbox.push) begin
				wptr <= wptr + 1'b1;  // depth is a power of two, pointers wrap
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
			case ({mbox.push, pop})
				2'b10:   fcount <= fcount + 1'b1;
				2'b01:   fcount <= fcount - 1'b1;
				default: ;  // idle or push and pop together
			endcase
		end
	end

	// fetch / decode / execute
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= useq_pkg::FETCH;
			instr        <= useq_pkg::NOP;
			pc           <= '0;
			a            <= 8'd0;
			l_i_port     <= 8'd0;
			int_mask     <= 8'd0;
			int_en       <= 1'b0;
			o_port       <= 8'd0;
			o_port_pulse <= 1'b0;
		end else begin
			l_i_port <= i_port;
			if (int_hit) begin
				// abandon the instruction in flight, RTI re-runs it from ilr
				ilr    <= pc;
				ta     <= a;
				int_en <= 1'b0;
				pc     <= `USEQ_ROM_AW'(`USEQ_ISR_VECT);
				state  <= useq_pkg::FETCH;
			end else begin
				case (state)
					useq_pkg::FETCH: begin
						if (mbox.run) begin
							state <= useq_pkg::DECODE;  // halted core parks here
						end
					end
					useq_pkg::DECODE: begin
						instr <= useq_pkg::opcode_t'(rom_data[7:0]);
						imm   <= rom_data[15:8];
						state <= useq_pkg::EXECUTE;
					end
					useq_pkg::EXECUTE: begin
						state <= useq_pkg::FETCH;
						pc    <= pc + 1'b1;
						case (instr)
							useq_pkg::LDI:  a <= imm;
							useq_pkg::ADDP: a <= a + l_i_port;  // wraps mod 256
							useq_pkg::POPF: begin
								if (fcount == 4'd0) begin
									state <= useq_pkg::EXECUTE;  // wait for a byte
									pc    <= pc;
								end else begin
									a <= fifo_mem[rptr];
								end
							end
							useq_pkg::OUT: begin
								o_port       <= a;
								o_port_pulse <= ~o_port_pulse;  // collector watches the toggle
							end
							useq_pkg::JMP: pc <= `USEQ_ROM_AW'(imm);
							useq_pkg::SEI: begin
								int_mask <= imm;
								int_en   <= 1'b1;
							end
							useq_pkg::RTI: begin
								pc     <= ilr;
								a      <= ta;
								int_en <= 1'b1;
							end
							default: ;  // NOP and unknown opcodes just advance
						endcase
					end
					default: state <= useq_pkg::FETCH;
				endcase
			end
		end
	end

endmodule

//--- useq_wb_host.sv
`timescale 1ns/1ps
`include "useq_defs.svh"

module useq_wb_host (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [`USEQ_WB_AW-1:0] adr,
	input  logic [7:0]             dat_w,
	output logic [7:0]             dat_r,
	output logic                   ack,
	useq_mbox_if.host              mbox [`USEQ_NCORES]
);
	localparam int NC = `USEQ_NCORES;
	localparam int CW = $clog2(NC);

	logic          acc;   // access accepted this cycle
	logic [CW-1:0] sel;   // core select
	logic [1:0]    rsel;  // register select
	logic [NC-1:0] run;
	logic [NC-1:0] drop;  // sticky until reset
	logic [NC-1:0] full;

	useq_pkg::mbox_status_t status [NC];

	assign acc  = cyc && stb && !ack;  // no back-to-back ack
	assign sel  = adr[`USEQ_WB_AW-1:2];
	assign rsel = adr[1:0];

	for (genvar i = 0; i < NC; i++) begin : g_mbox
		assign mbox[i].run   = run[i];
		assign mbox[i].wdata = dat_w;
		// reg 0 write, byte goes in the same edge as ack rises
		assign mbox[i].push  = acc && we && (rsel == 2'd0) && (sel == CW'(i)) && !mbox[i].full;
		assign full[i]       = mbox[i].full;
		assign status[i]     = '{
			run:   run[i],
			drop:  drop[i],
			full:  mbox[i].full,
			empty: (mbox[i].count == 4'd0),  // derived here, core only gives count
			count: mbox[i].count
		};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack  <= 1'b0;
			run  <= '0;  // all cores come up halted
			drop <= '0;
		end else begin
			ack <= acc;
			if (acc && we) begin
				case (rsel)
					2'd0: begin
						if (full[sel]) begin
							drop[sel] <= 1'b1;  // byte discarded
						end
					end
					2'd2:    run[sel] <= dat_w[0];
					default: ;  // status is read-only
				endcase
			end
		end
	end

	// read data registered alongside ack
	always_ff @(posedge clk) begin
		if (acc && !we) begin
			case (rsel)
				2'd1:    dat_r <= status[sel];
				2'd2:    dat_r <= {7'd0, run[sel]};
				default: dat_r <= 8'd0;  // mailbox and spare read as zero
			endcase
		end
	end

endmodule

//--- useq_out_collect.sv
`timescale 1ns/1ps
`include "useq_defs.svh"

module useq_out_collect (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [`USEQ_NCORES*8-1:0]        o_port,
	input  logic [`USEQ_NCORES-1:0]          o_port_pulse,
	input  logic                             ev_ready,
	output logic                             ev_valid,
	output logic [$clog2(`USEQ_NCORES)-1:0]  ev_core,
	output logic [7:0]                       ev_data,
	output logic                             ev_lost
);
	localparam int NC = `USEQ_NCORES;
	localparam int CW = $clog2(NC);

	logic [NC-1:0] prev_pulse;
	logic [NC-1:0] toggle;     // output write seen one cycle late
	logic [NC-1:0] slot_full;
	logic [7:0]    slot_data [NC];
	logic [CW-1:0] rr;         // round-robin start point
	logic [CW-1:0] pick;
	logic          found;
	logic          take;       // output register free or being taken
	logic [NC-1:0] drain;

	assign toggle = o_port_pulse ^ prev_pulse;
	assign take   = !ev_valid || ev_ready;
	assign drain  = (take && found) ? (NC'(1) << pick) : '0;

	// first full slot at or after rr
	always_comb begin
		logic [CW-1:0] idx;
		pick  = rr;
		found = 1'b0;
		for (int j = 0; j < NC; j++) begin
			idx = CW'((int'(rr) + j) % NC);
			if (!found && slot_full[idx]) begin
				pick  = idx;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prev_pulse <= '0;
			slot_full  <= '0;
			rr         <= '0;
			ev_valid   <= 1'b0;
			ev_lost    <= 1'b0;
		end else begin
			prev_pulse <= o_port_pulse;
			if (take) begin
				ev_valid <= found;
				if (found) begin
					rr <= (pick == CW'(NC - 1)) ? '0 : pick + 1'b1;
				end
			end
			for (int k = 0; k < NC; k++) begin
				if (toggle[k]) begin
					if (slot_full[k] && !drain[k]) begin
						ev_lost <= 1'b1;  // slot still occupied, new byte lost
					end else begin
						slot_full[k] <= 1'b1;
					end
				end else if (drain[k]) begin
					slot_full[k] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < NC; k++) begin
			if (toggle[k] && (!slot_full[k] || drain[k])) begin
				slot_data[k] <= o_port[k*8 +: 8];
			end
		end
		if (take && found) begin
			ev_core <= pick;  // holds while stalled
			ev_data <= slot_data[pick];
		end
	end

endmodule

//--- useq_cluster.sv
`timescale 1ns/1ps
`include "useq_defs.svh"

module useq_cluster (
	input  logic                             clk,
	input  logic                             rst_n,
	// wishbone classic slave
	input  logic                             cyc,
	input  logic                             stb,
	input  logic                             we,
	input  logic [`USEQ_WB_AW-1:0]           adr,
	input  logic [7:0]                       dat_w,
	output logic [7:0]                       dat_r,
	output logic                             ack,
	// input ports, 8 bits per core
	input  logic [`USEQ_NCORES*8-1:0]        i_port,
	// event stream
	output logic                             ev_valid,
	input  logic                             ev_ready,
	output logic [$clog2(`USEQ_NCORES)-1:0]  ev_core,
	output logic [7:0]                       ev_data,
	output logic                             ev_lost
);
	localparam int NC = `USEQ_NCORES;

	useq_mbox_if mbox [NC] ();  // host to core links

	logic [`USEQ_ROM_AW-1:0] rom_addr [NC];
	logic [15:0]             rom_data [NC];
	logic [NC*8-1:0]         o_port;        // all output ports, core 0 in the low byte
	logic [NC-1:0]           o_port_pulse;

	useq_wb_host u_host (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack),
		.mbox  (mbox)
	);

	// one core per rom, all roms load the same image
	for (genvar g = 0; g < NC; g++) begin : g_core
		useq_rom u_rom (
			.clk  (clk),
			.addr (rom_addr[g]),
			.data (rom_data[g])
		);

		useq_core u_core (
			.clk          (clk),
			.rst_n        (rst_n),
			.mbox         (mbox[g]),
			.rom_addr     (rom_addr[g]),
			.rom_data     (rom_data[g]),
			.i_port       (i_port[g*8 +: 8]),
			.o_port       (o_port[g*8 +: 8]),
			.o_port_pulse (o_port_pulse[g])
		);
	end

	useq_out_collect u_collect (
		.clk          (clk),
		.rst_n        (rst_n),
		.o_port       (o_port),
		.o_port_pulse (o_port_pulse),
		.ev_ready     (ev_ready),
		.ev_valid     (ev_valid),
		.ev_core      (ev_core),
		.ev_data      (ev_data),
		.ev_lost      (ev_lost)
	);

endmodule

//--- useq_chk.sv
`timescale 1ns/1ps
`include "useq_defs.svh"

module useq_chk (
	input logic                            clk,
	input logic                            rst_n,
	input logic                            cyc,
	input logic                            stb,
	input logic                            ack,
	input logic                            ev_valid,
	input logic                            ev_ready,
	input logic [$clog2(`USEQ_NCORES)-1:0] ev_core,
	input logic [7:0]                      ev_data,
	input logic                            ev_lost
);
	int fail_count = 0;  // read by the testbench

	// ack only answers a live request
	a_ack_req: assert property (@(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb))
		else begin
			$error("ack high without cyc and stb");
			fail_count++;
		end

	// single-cycle ack, never back to back
	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else begin
			$error("ack high for two cycles in a row");
			fail_count++;
		end

	// stalled event keeps valid, core and data
	a_ev_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(ev_valid && !ev_ready) |=> (ev_valid && $stable(ev_core) && $stable(ev_data)))
		else begin
			$error("event stream changed while stalled");
			fail_count++;
		end

	// sync reset clears the outputs by the next edge
	a_reset: assert property (@(posedge clk) !rst_n |=> (!ack && !ev_valid && !ev_lost))
		else begin
			$error("ack, ev_valid or ev_lost high after reset");
			fail_count++;
		end

endmodule

bind useq_cluster useq_chk u_chk (.*);

//--- useq_tb.sv
`timescale 1ns/1ps
`include "useq_defs.svh"

module useq_tb;
	localparam int NC              = `USEQ_NCORES;
	localparam int DRAIN_CYCLES    = 400;   // 8 queued bytes at 12 cycles each, plus margin
	localparam int WATCHDOG_CYCLES = 4000;  // whole run is roughly 1000 cycles

	logic                   clk;
	logic                   rst_n;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic [`USEQ_WB_AW-1:0] adr;
	logic [7:0]             dat_w;
	logic [7:0]             dat_r;
	logic                   ack;
	logic [NC*8-1:0]        i_port;
	logic                   ev_valid;
	logic                   ev_ready;
	logic [$clog2(NC)-1:0]  ev_core;
	logic [7:0]             ev_data;
	logic                   ev_lost;

	integer     seed = 32'hfe30111c;
	logic       stall_on;   // random back-pressure on ev_ready
	string      test_name;
	logic [9:0] exp_q [$];  // {core, byte}, in push order

	useq_cluster dut0 (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		if (stall_on) begin
			ev_ready <= (($random(seed) & 3) != 0);  // ready three cycles out of four
		end else begin
			ev_ready <= 1'b1;
		end
	end

	task automatic abort();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected) else begin
			$display("** Error %s %s: expected %02h, actual %02h", test_name, what,
				expected, actual);
			abort();
		end
	endtask

	// status byte as laid out in the register map
	function automatic logic [7:0] status_word(input logic run, input logic drop,
		input logic full, input logic empty, input logic [3:0] count);
		return {run, drop, full, empty, count};
	endfunction

	task automatic wait_ack();
		int n = 0;
		do begin
			@(posedge clk);
			n++;
			assert (n <= 8) else begin
				$display("no wishbone ack within 8 cycles in %s", test_name);
				abort();
			end
		end while (!ack);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic wb_write(input int core, input int rsel, input logic [7:0] data);
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= 1'b1;
		adr   <= {2'(core), 2'(rsel)};
		dat_w <= data;
		wait_ack();
	endtask

	task automatic wb_read(input int core, input int rsel, output logic [7:0] data);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we  <= 1'b0;
		adr <= {2'(core), 2'(rsel)};
		wait_ack();
		data = dat_r;  // registered together with ack
	endtask

	task automatic check_reg(input int core, input int rsel, input logic [7:0] expected);
		logic [7:0] rd;
		wb_read(core, rsel, rd);
		check_value($sformatf("core %0d reg %0d", core, rsel), expected, rd);
	endtask

	// byte b to core k comes back as b + i_port[k]
	task automatic push_byte(input int core, input logic [7:0] b);
		logic [7:0] sum;
		sum = b + i_port[core*8 +: 8];  // mod 256
		exp_q.push_back({2'(core), sum});
		wb_write(core, 0, b);
	endtask

	task automatic wait_drain();
		int n = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			n++;
			assert (n <= DRAIN_CYCLES) else begin
				$display("%0d expected events never arrived in %s", exp_q.size(), test_name);
				abort();
			end
		end
	endtask

	// scoreboard, first queued entry of the same core must match
	always @(posedge clk) begin : monitor
		int idx;
		if (rst_n && ev_valid && ev_ready) begin
			idx = -1;
			for (int i = 0; i < exp_q.size(); i++) begin
				if (idx < 0 && exp_q[i][9:8] == ev_core) begin
					idx = i;
				end
			end
			assert (idx >= 0) else begin
				$display("unexpected event from core %0d, data %02h, in %s", ev_core, ev_data,
					test_name);
				abort();
			end
			check_value($sformatf("core %0d event", ev_core), exp_q[idx][7:0], ev_data);
			exp_q.delete(idx);
		end
	end

	// protocol checker failures end the run at once
	always @(posedge clk) begin
		if (dut0.u_chk.fail_count != 0) begin
			$display("protocol checker flagged an assertion failure in %s", test_name);
			abort();
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
		abort();
	end

	initial begin
		int tmp;
		clk      = 1'b0;
		rst_n    = 1'b0;
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		adr      = '0;
		dat_w    = 8'd0;
		ev_ready = 1'b1;
		stall_on = 1'b0;
		i_port   = $random(seed) & 32'h7f7f7f7f;  // bit 7 low on every core
		test_name = "reset";
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "ctrl_status";
		for (int k = 0; k < NC; k++) begin
			check_reg(k, 1, status_word(1'b0, 1'b0, 1'b0, 1'b1, 4'd0));
		end
		wb_write(0, 2, 8'h01);
		check_reg(0, 2, 8'h01);
		wb_write(0, 2, 8'h00);
		check_reg(0, 2, 8'h00);

		test_name = "mbox_full";
		for (int n = 0; n < 8; n++) begin
			tmp = $random(seed);
			push_byte(2, tmp[7:0]);
		end
		wb_write(2, 0, 8'h5a);  // ninth byte, mailbox already full
		check_reg(2, 1, status_word(1'b0, 1'b1, 1'b1, 1'b0, 4'd8));
		wb_write(2, 2, 8'h01);
		wait_drain();

		test_name = "stream";
		for (int k = 0; k < NC; k++) begin
			wb_write(k, 2, 8'h01);
		end
		stall_on <= 1'b1;
		for (int n = 0; n < 40; n++) begin
			tmp = $random(seed);
			push_byte(tmp[1:0], tmp[15:8]);
			repeat (tmp[18:16] + 2) @(posedge clk);  // gap keeps mailboxes below full
		end
		wait_drain();
		stall_on <= 1'b0;
		check_value("ev_lost", 8'h00, {7'd0, ev_lost});

		test_name = "interrupt";
		exp_q.push_back({2'd1, 8'ha5});
		@(posedge clk);
		i_port[15] <= 1'b1;  // rising edge on bit 7 of core 1
		wait_drain();
		tmp = $random(seed);
		push_byte(1, tmp[7:0]);  // sum now includes bit 7
		wait_drain();

		test_name = "halt";
		wb_write(3, 2, 8'h00);
		tmp = $random(seed);
		push_byte(3, tmp[7:0]);
		for (int n = 0; n < 100; n++) begin
			@(posedge clk);
			assert (!ev_valid) else begin
				$display("event seen while core 3 was halted in %s", test_name);
				abort();
			end
		end
		wb_write(3, 2, 8'h01);
		wait_drain();

		repeat (10) @(posedge clk);  // room for a stray extra event
		if (dut0.u_chk.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("protocol checker flagged %0d assertion failures",
				dut0.u_chk.fail_count);
			abort();
		end
	end

endmodule

//--- useq_prog.hex
// one 16-bit word per line, {imm, opcode} with the opcode in the low byte
// main loop from 00, interrupt handler from 40
@00
8006  // SEI 80, only bit 7 can interrupt
0003  // POPF
0002  // ADDP
0004  // OUT
0105  // JMP 01
@40
A501  // LDI A5
0004  // OUT
0007  // RTI

//--- sim.f
+incdir+.
useq_pkg.sv
useq_mbox_if.sv
useq_rom.sv
useq_core.sv
useq_wb_host.sv
useq_out_collect.sv
useq_cluster.sv
useq_chk.sv
useq_tb.sv
